// ==== list.f ====
+incdir+rtl
rtl/csr_cfg_pkg.sv
rtl/sync_fifo.sv
rtl/response_filter.sv
rtl/config_assembler.sv
rtl/csr_index_config_memory.sv
verification/tb_csr_index_config_memory.sv

// ==== verification/tb_csr_index_config_memory.sv ====
`timescale 1ns/1ps
`include "csr_cfg_defines.svh"

module tb_csr_index_config_memory;

    localparam int engine_slot = 1;
    localparam int slots       = `CSR_SEQ_SLOTS;
    localparam int window_base = engine_slot * slots;

    // Words sent over the whole run, tests 2 to 6
    localparam int total_words     = 16 + 16 + 32 + 48 + 32;
    localparam int watchdog_cycles = total_words * 40 + 500;

    localparam csr_cfg_pkg::fifo_status_t idle_status = '{full: 1'b0, empty: 1'b1, prog_full: 1'b0};

    logic                           ap_clk;
    logic                           areset_csr_index_generator;
    csr_cfg_pkg::mem_response_t     response_in;
    logic                           response_drain;
    logic                           config_pop;
    logic                           config_valid;
    csr_cfg_pkg::csr_index_config_t config_out;
    csr_cfg_pkg::fifo_status_t      response_fifo_status;
    csr_cfg_pkg::fifo_status_t      config_fifo_status;

    // Reference model state
    csr_cfg_pkg::csr_index_config_t expected_q[$];
    csr_cfg_pkg::csr_index_config_t expected_rec;
    logic [`CSR_DATA_W-1:0]         slot_data [slots];
    int                             slot_order [slots];

    string test_name;
    int    errors;
    int    records_checked;
    logic  output_blocked;

    csr_index_config_memory #(
        .engine_slot(engine_slot)
    ) dut (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_in               (response_in),
        .response_drain            (response_drain),
        .config_pop                (config_pop),
        .config_valid              (config_valid),
        .config_out                (config_out),
        .response_fifo_status      (response_fifo_status),
        .config_fifo_status        (config_fifo_status)
    );

    initial ap_clk = 1'b0;
    always #4 ap_clk = ~ap_clk;

    // ----------------------------------------
    // Reference model and stimulus
    // ----------------------------------------

    // Decode of one complete sequence
    function automatic csr_cfg_pkg::csr_index_config_t expected_record();
        csr_cfg_pkg::csr_index_config_t rec;
        rec.increment     = slot_data[`CSR_SLOT_FLAGS][0];
        rec.decrement     = slot_data[`CSR_SLOT_FLAGS][1];
        rec.mode_sequence = slot_data[`CSR_SLOT_FLAGS][2];
        rec.mode_buffer   = slot_data[`CSR_SLOT_FLAGS][3];
        rec.index_start   = slot_data[`CSR_SLOT_INDEX_START];
        rec.index_end     = slot_data[`CSR_SLOT_INDEX_END];
        rec.stride        = slot_data[`CSR_SLOT_STRIDE];
        rec.granularity   = slot_data[`CSR_SLOT_GRANULARITY];
        rec.cmd           = csr_cfg_pkg::memory_cmd_e'(slot_data[`CSR_SLOT_CMD][1:0]);
        rec.array_pointer = {slot_data[`CSR_SLOT_PTR_HI], slot_data[`CSR_SLOT_PTR_LO]};
        rec.array_size    = slot_data[`CSR_SLOT_ARRAY_SIZE];
        return rec;
    endfunction

    // Random shift with random low offset bits, same sequence number
    task automatic send_word(input csr_cfg_pkg::buffer_kind_e kind,
                             input int unsigned seq,
                             input logic [`CSR_DATA_W-1:0] data);
        int unsigned            shift;
        logic [`CSR_ADDR_W-1:0] low_bits;
        shift    = $urandom_range(12, 0);
        low_bits = $urandom & ((32'd1 << shift) - 32'd1);
        @(negedge ap_clk);
        response_in.valid  = 1'b1;
        response_in.kind   = kind;
        response_in.offset = (`CSR_ADDR_W'(seq) << shift) | low_bits;
        response_in.shift  = `CSR_SHIFT_W'(shift);
        response_in.data   = data;
    endtask

    task automatic idle_cycles(input int cycles);
        repeat (cycles) begin
            @(negedge ap_clk);
            response_in.valid = 1'b0;
        end
    endtask

    // Wrong kind inside the window, or setup kind outside it
    task automatic send_junk(input int unsigned seq);
        int unsigned pick;
        pick = $urandom_range(3, 0);
        case (pick)
            0: send_word(csr_cfg_pkg::buf_data, seq, $urandom);
            1: send_word(csr_cfg_pkg::buf_none, seq, $urandom);
            2: send_word(csr_cfg_pkg::buf_engine_setup, $urandom_range(window_base - 1, 0),
                         $urandom);
            default: send_word(csr_cfg_pkg::buf_cu_setup,
                               window_base + slots + $urandom_range(31, 0), $urandom);
        endcase
    endtask

    task automatic send_sequence(input bit shuffle, input bit mix_kinds, input bit with_junk);
        int                        j;
        int                        tmp;
        csr_cfg_pkg::buffer_kind_e kind;
        for (int s = 0; s < slots; s++) begin
            slot_data[s]  = $urandom;
            slot_order[s] = s;
        end
        if (shuffle) begin
            for (int s = slots - 1; s > 0; s--) begin
                j             = $urandom_range(s, 0);
                tmp           = slot_order[s];
                slot_order[s] = slot_order[j];
                slot_order[j] = tmp;
            end
        end
        for (int s = 0; s < slots; s++) begin
            kind = csr_cfg_pkg::buf_engine_setup;
            if (mix_kinds && $urandom_range(1, 0) == 1) begin
                kind = csr_cfg_pkg::buf_cu_setup;
            end
            send_word(kind, window_base + slot_order[s], slot_data[slot_order[s]]);
            if (with_junk) begin
                send_junk(window_base + slot_order[s]);
            end
            if ($urandom_range(3, 0) == 0) begin
                idle_cycles(1);
            end
        end
        idle_cycles(1);
        expected_q.push_back(expected_record());
    endtask

    task automatic wait_for_records(input int max_cycles);
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < max_cycles) begin
            @(negedge ap_clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            errors++;
            $display("%s: %0d records still missing after %0d cycles", test_name,
                     expected_q.size(), max_cycles);
            expected_q.delete();
        end
        // Room for a stray extra record to show up
        repeat (20) @(negedge ap_clk);
    endtask

    task automatic wait_response_fifo(input bit want_full, input int max_cycles);
        int waited;
        waited = 0;
        while (waited < max_cycles &&
               !(want_full ? response_fifo_status.full : response_fifo_status.empty)) begin
            @(negedge ap_clk);
            waited++;
        end
        if (waited >= max_cycles) begin
            errors++;
            $display("%s: response FIFO never became %s", test_name, want_full ? "full" : "empty");
        end
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    always @(negedge ap_clk) begin
        if (!areset_csr_index_generator && config_valid) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("%s: config_valid while no record was expected", test_name);
            end else begin
                expected_rec = expected_q.pop_front();
                records_checked++;
                record_matches : assert (config_out == expected_rec) else begin
                    errors++;
                    $display("Mismatch in %s: expected %h, actual %h", test_name,
                             expected_rec, config_out);
                end
            end
        end
    end

    no_output_while_blocked : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        output_blocked |-> !config_valid
    ) else begin
        errors++;
        $display("%s: config_valid rose while the output was held back", test_name);
    end

    config_fifo_never_full : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        !config_fifo_status.full
    ) else begin
        errors++;
        $display("%s: configuration FIFO ran full", test_name);
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'h205125be));
        areset_csr_index_generator = 1'b1;
        response_in                = '0;
        response_drain             = 1'b1;
        config_pop                 = 1'b1;
        output_blocked             = 1'b0;
        errors                     = 0;
        records_checked            = 0;
        test_name                  = "reset";
        repeat (2) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_csr_index_generator = 1'b0;

        test_name = "after_reset";
        @(negedge ap_clk);
        valid_low_after_reset : assert (config_valid == 1'b0) else begin
            errors++;
            $display("Mismatch in %s: expected %b, actual %b", test_name, 1'b0, config_valid);
        end
        response_idle : assert (response_fifo_status == idle_status) else begin
            errors++;
            $display("Mismatch in %s: expected %b, actual %b", test_name, idle_status,
                     response_fifo_status);
        end
        config_idle : assert (config_fifo_status == idle_status) else begin
            errors++;
            $display("Mismatch in %s: expected %b, actual %b", test_name, idle_status,
                     config_fifo_status);
        end

        test_name = "in_order";
        send_sequence(1'b0, 1'b0, 1'b0);
        wait_for_records(slots * 40);

        test_name = "shuffled_mixed_kinds";
        send_sequence(1'b1, 1'b1, 1'b0);
        wait_for_records(slots * 40);

        test_name = "interleaved_junk";
        send_sequence(1'b1, 1'b1, 1'b1);
        wait_for_records(2 * slots * 40);

        // Records pile up in the configuration FIFO
        test_name = "held_output";
        @(negedge ap_clk);
        config_pop     = 1'b0;
        output_blocked = 1'b1;
        repeat (3) send_sequence(1'b1, 1'b1, 1'b0);
        wait_response_fifo(1'b0, 200);
        repeat (12) @(negedge ap_clk);
        config_pop     = 1'b1;
        output_blocked = 1'b0;
        wait_for_records(3 * slots * 40);

        // Two sequences fill the response FIFO exactly
        test_name = "drain_held";
        @(negedge ap_clk);
        response_drain = 1'b0;
        output_blocked = 1'b1;
        repeat (2) send_sequence(1'b1, 1'b0, 1'b0);
        wait_response_fifo(1'b1, 200);
        repeat (12) @(negedge ap_clk);
        response_drain = 1'b1;
        output_blocked = 1'b0;
        wait_for_records(2 * slots * 40);

        $display("records checked: %0d, errors: %0d", records_checked, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge ap_clk);
        $display("Watchdog expired after %0d cycles during %s", watchdog_cycles, test_name);
        $display("records checked: %0d, errors: %0d", records_checked, errors);
        $display("test failed");
        $finish;
    end

endmodule : tb_csr_index_config_memory

// ==== rtl/csr_index_config_memory.sv ====
`timescale 1ns/1ps
`include "csr_cfg_defines.svh"

module csr_index_config_memory #(
    parameter int engine_slot = 0
) (
    input  logic                           ap_clk,
    input  logic                           areset_csr_index_generator,
    input  csr_cfg_pkg::mem_response_t     response_in,
    input  logic                           response_drain,
    input  logic                           config_pop,
    output logic                           config_valid,
    output csr_cfg_pkg::csr_index_config_t config_out,
    output csr_cfg_pkg::fifo_status_t      response_fifo_status,
    output csr_cfg_pkg::fifo_status_t      config_fifo_status
);

    // Response path
    logic                           resp_push;
    csr_cfg_pkg::mem_response_t     resp_push_word;
    logic                           resp_rd_en;
    logic                           resp_rd_valid;
    csr_cfg_pkg::mem_response_t     resp_rd_data;
    csr_cfg_pkg::fifo_status_t      resp_status;

    // Configuration path
    logic                           cfg_push;
    csr_cfg_pkg::csr_index_config_t cfg_push_word;
    logic                           cfg_rd_valid;
    csr_cfg_pkg::csr_index_config_t cfg_rd_data;
    csr_cfg_pkg::fifo_status_t      cfg_status;

    // ----------------------------------------
    // Filter and response FIFO
    // ----------------------------------------
    response_filter #(
        .engine_slot(engine_slot)
    ) u_filter (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_in               (response_in),
        .push                      (resp_push),
        .push_word                 (resp_push_word)
    );

    sync_fifo #(
        .width      ($bits(csr_cfg_pkg::mem_response_t)),
        .depth      (`CSR_FIFO_DEPTH),
        .prog_thresh(`CSR_FIFO_PROG_THRESH)
    ) u_response_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .push                      (resp_push),
        .wr_data                   (resp_push_word),
        .rd_en                     (resp_rd_en),
        .rd_data                   (resp_rd_data),
        .rd_valid                  (resp_rd_valid),
        .status                    (resp_status)
    );

    // ----------------------------------------
    // Assembler and configuration FIFO
    // ----------------------------------------
    config_assembler #(
        .engine_slot(engine_slot)
    ) u_assembler (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_drain            (response_drain),
        .config_fifo_prog_full     (cfg_status.prog_full),
        .rd_en                     (resp_rd_en),
        .rd_valid                  (resp_rd_valid),
        .rd_data                   (resp_rd_data),
        .push                      (cfg_push),
        .config_word               (cfg_push_word)
    );

    sync_fifo #(
        .width      ($bits(csr_cfg_pkg::csr_index_config_t)),
        .depth      (`CSR_FIFO_DEPTH),
        .prog_thresh(`CSR_FIFO_PROG_THRESH)
    ) u_config_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .push                      (cfg_push),
        .wr_data                   (cfg_push_word),
        .rd_en                     (config_pop),
        .rd_data                   (cfg_rd_data),
        .rd_valid                  (cfg_rd_valid),
        .status                    (cfg_status)
    );

    // ----------------------------------------
    // Output register stage
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            config_valid         <= 1'b0;
            response_fifo_status <= '{full: 1'b0, empty: 1'b1, prog_full: 1'b0};
            config_fifo_status   <= '{full: 1'b0, empty: 1'b1, prog_full: 1'b0};
        end else begin
            config_valid         <= cfg_rd_valid;
            response_fifo_status <= resp_status;
            config_fifo_status   <= cfg_status;
        end
    end

    always_ff @(posedge ap_clk) begin
        config_out <= cfg_rd_data;
    end

endmodule : csr_index_config_memory

// ==== rtl/config_assembler.sv ====
`timescale 1ns/1ps
`include "csr_cfg_defines.svh"

module config_assembler #(
    parameter int engine_slot = 0
) (
    input  logic                           ap_clk,
    input  logic                           areset_csr_index_generator,
    input  logic                           response_drain,
    input  logic                           config_fifo_prog_full,
    output logic                           rd_en,
    input  logic                           rd_valid,
    input  csr_cfg_pkg::mem_response_t     rd_data,
    output logic                           push,
    output csr_cfg_pkg::csr_index_config_t config_word
);

    localparam int slot_w = $clog2(`CSR_SEQ_SLOTS);
    localparam logic [`CSR_ADDR_W-1:0] seq_min = `CSR_ADDR_W'(engine_slot * `CSR_SEQ_SLOTS);

    logic [`CSR_SEQ_SLOTS-1:0]      slot_mask;
    logic [`CSR_SEQ_SLOTS-1:0]      slot_hit;
    logic                           mask_full;
    logic [`CSR_ADDR_W-1:0]         seq_rel;
    logic [slot_w-1:0]              rel_slot;
    logic [`CSR_DATA_W-1:0]         word;
    csr_cfg_pkg::csr_index_config_t record_q;

    // ----------------------------------------
    // Pop control
    // ----------------------------------------
    assign mask_full = &slot_mask;
    // Hold off while a record waits to go out or downstream is backing up
    assign rd_en     = response_drain & ~mask_full & ~config_fifo_prog_full;

    // Slot of the word coming out of the response FIFO
    assign seq_rel  = csr_cfg_pkg::sequence_number(rd_data) - seq_min;
    assign rel_slot = seq_rel[slot_w-1:0];
    assign word     = rd_data.data;

    always_comb begin
        slot_hit = '0;
        if (rd_valid) begin
            slot_hit[rel_slot] = 1'b1;
        end
    end

    // ----------------------------------------
    // Slot mask and push strobe
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            slot_mask <= '0;
            push      <= 1'b0;
        end else begin
            push <= mask_full;
            // A word popped just before the pause starts the next record
            if (mask_full) begin
                slot_mask <= slot_hit;
            end else begin
                slot_mask <= slot_mask | slot_hit;
            end
        end
    end

    // ----------------------------------------
    // Field decode
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rd_valid) begin
            case (rel_slot)
                `CSR_SLOT_FLAGS: begin
                    record_q.increment     <= word[0];
                    record_q.decrement     <= word[1];
                    record_q.mode_sequence <= word[2];
                    record_q.mode_buffer   <= word[3];
                end
                `CSR_SLOT_INDEX_START: begin
                    record_q.index_start <= word;
                end
                `CSR_SLOT_INDEX_END: begin
                    record_q.index_end <= word;
                end
                `CSR_SLOT_STRIDE: begin
                    record_q.stride <= word;
                end
                `CSR_SLOT_GRANULARITY: begin
                    record_q.granularity <= word;
                end
                `CSR_SLOT_CMD: begin
                    record_q.cmd <= csr_cfg_pkg::memory_cmd_e'(word[1:0]);
                end
                `CSR_SLOT_PTR_LO: begin
                    record_q.array_pointer[`CSR_DATA_W-1:0] <= word;
                end
                `CSR_SLOT_PTR_HI: begin
                    record_q.array_pointer[`CSR_PTR_W-1:`CSR_DATA_W] <= word;
                end
                `CSR_SLOT_ARRAY_SIZE: begin
                    record_q.array_size <= word;
                end
                // Remaining slots only mark arrival
                default: begin
                    record_q <= record_q;
                end
            endcase
        end
    end

    // Snapshot of the complete record, aligned with push
    always_ff @(posedge ap_clk) begin
        if (mask_full) begin
            config_word <= record_q;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    push_needs_full_mask : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        push |-> $past(mask_full)
    ) else $error("config_assembler: record pushed with incomplete slot mask");

    // Only the low bits of the relative slot select a field
    word_in_window : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        rd_valid |-> (seq_rel < `CSR_ADDR_W'(`CSR_SEQ_SLOTS))
    ) else $error("config_assembler: popped word lies outside the engine window");

endmodule : config_assembler

// ==== rtl/response_filter.sv ====
`timescale 1ns/1ps
`include "csr_cfg_defines.svh"

module response_filter #(
    parameter int engine_slot = 0
) (
    input  logic                       ap_clk,
    input  logic                       areset_csr_index_generator,
    input  csr_cfg_pkg::mem_response_t response_in,
    output logic                       push,
    output csr_cfg_pkg::mem_response_t push_word
);

    // Window owned by this engine
    localparam logic [`CSR_ADDR_W-1:0] seq_min = `CSR_ADDR_W'(engine_slot * `CSR_SEQ_SLOTS);
    localparam logic [`CSR_ADDR_W-1:0] seq_max = seq_min + `CSR_ADDR_W'(`CSR_SEQ_SLOTS);

    csr_cfg_pkg::mem_response_t resp_q;
    logic                       resp_valid_q;
    logic [`CSR_ADDR_W-1:0]     seq;
    logic                       kind_ok;
    logic                       in_window;

    // ----------------------------------------
    // Input register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= response_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_q <= response_in;
    end

    // ----------------------------------------
    // Window filter
    // ----------------------------------------
    assign seq       = csr_cfg_pkg::sequence_number(resp_q);
    // Only setup traffic configures the engine
    assign kind_ok   = (resp_q.kind == csr_cfg_pkg::buf_cu_setup) ||
                       (resp_q.kind == csr_cfg_pkg::buf_engine_setup);
    assign in_window = (seq >= seq_min) && (seq < seq_max);
    assign push      = resp_valid_q & kind_ok & in_window;

    always_comb begin
        push_word       = resp_q;
        push_word.valid = resp_valid_q;
    end

endmodule : response_filter

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int width       = 32,
    parameter int depth       = 32,
    parameter int prog_thresh = 16
) (
    input  logic                      ap_clk,
    input  logic                      areset_csr_index_generator,
    input  logic                      push,
    input  logic [width-1:0]          wr_data,
    input  logic                      rd_en,
    output logic [width-1:0]          rd_data,
    output logic                      rd_valid,
    output csr_cfg_pkg::fifo_status_t status
);

    localparam int addr_w = (depth > 1) ? $clog2(depth) : 1;

    logic [width-1:0]  mem [depth];
    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    logic [addr_w:0]   count;
    logic              wr_accept;
    logic              rd_accept;

    // ----------------------------------------
    // Flags and accept strobes
    // ----------------------------------------
    always_comb begin
        status.full      = (count == depth);
        status.empty     = (count == 0);
        status.prog_full = (count >= prog_thresh);
    end

    // A push into a full FIFO is dropped
    assign wr_accept = push & ~status.full;
    assign rd_accept = rd_en & ~status.empty;

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_accept;
            if (wr_accept) begin
                wr_ptr <= (wr_ptr == addr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_accept) begin
                rd_ptr <= (rd_ptr == addr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_accept, rd_accept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd_accept) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    push_while_full : assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        !(push && status.full)
    ) else $error("sync_fifo: push while full, word lost");

endmodule : sync_fifo

// ==== rtl/csr_cfg_pkg.sv ====
`include "csr_cfg_defines.svh"

package csr_cfg_pkg;

    // ----------------------------------------
    // Enumerations
    // ----------------------------------------

    // Kind of buffer a memory response belongs to
    typedef enum logic [1:0] {
        buf_none         = 2'd0,
        buf_cu_setup     = 2'd1,
        buf_engine_setup = 2'd2,
        buf_data         = 2'd3
    } buffer_kind_e;

    // Memory command opcode carried in slot 5
    typedef enum logic [1:0] {
        cmd_invalid = 2'd0,
        cmd_read    = 2'd1,
        cmd_write   = 2'd2,
        cmd_stream  = 2'd3
    } memory_cmd_e;

    // ----------------------------------------
    // Structures
    // ----------------------------------------

    // One tagged response word from memory
    typedef struct packed {
        logic                     valid;
        buffer_kind_e             kind;
        logic [`CSR_ADDR_W-1:0]   offset;
        logic [`CSR_SHIFT_W-1:0]  shift;
        logic [`CSR_DATA_W-1:0]   data;
    } mem_response_t;

    // Finished configuration record of the index engine
    typedef struct packed {
        logic                     increment;
        logic                     decrement;
        logic                     mode_sequence;
        logic                     mode_buffer;
        logic [`CSR_DATA_W-1:0]   index_start;
        logic [`CSR_DATA_W-1:0]   index_end;
        logic [`CSR_DATA_W-1:0]   stride;
        logic [`CSR_DATA_W-1:0]   granularity;
        memory_cmd_e              cmd;
        logic [`CSR_PTR_W-1:0]    array_pointer;
        logic [`CSR_DATA_W-1:0]   array_size;
    } csr_index_config_t;

    // Occupancy flags of a FIFO
    typedef struct packed {
        logic full;
        logic empty;
        logic prog_full;
    } fifo_status_t;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Sequence number of a response, i.e. its offset in units of the shift
    function automatic logic [`CSR_ADDR_W-1:0] sequence_number(input mem_response_t word);
        return word.offset >> word.shift;
    endfunction

endpackage : csr_cfg_pkg

// ==== rtl/csr_cfg_defines.svh ====
`ifndef CSR_CFG_DEFINES_SVH
`define CSR_CFG_DEFINES_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define CSR_DATA_W 32
`define CSR_ADDR_W 32
`define CSR_SHIFT_W 5
// Array pointer spans two data words
`define CSR_PTR_W 64

// ----------------------------------------
// Window and FIFO sizing
// ----------------------------------------
`define CSR_SEQ_SLOTS 16
`define CSR_FIFO_DEPTH 32
`define CSR_FIFO_PROG_THRESH 16

// ----------------------------------------
// Relative slot numbers inside a window
// ----------------------------------------
`define CSR_SLOT_FLAGS 0
`define CSR_SLOT_INDEX_START 1
`define CSR_SLOT_INDEX_END 2
`define CSR_SLOT_STRIDE 3
`define CSR_SLOT_GRANULARITY 4
`define CSR_SLOT_CMD 5
`define CSR_SLOT_PTR_LO 8
`define CSR_SLOT_PTR_HI 9
`define CSR_SLOT_ARRAY_SIZE 10

`endif
